// ==== mem_ifs.sv ====
`timescale 1ns/1ps

// controller to RAM, one write port and one read port
interface ram_port_if #(
    parameter int ADDR_WIDTH = 6
);
    import wb_pkg::*;

    wb_sel_t wen;
    logic [ADDR_WIDTH-1:0] waddr;
    wb_data_t wdata;
    logic ren;
    logic [ADDR_WIDTH-1:0] raddr;
    // valid one clock after ren
    wb_data_t rdata;

    modport ctrl (
        output wen,
        output waddr,
        output wdata,
        output ren,
        output raddr,
        input rdata
    );

    modport mem (
        input wen,
        input waddr,
        input wdata,
        input ren,
        input raddr,
        output rdata
    );
endinterface

// controller to posted-write queue
interface wq_port_if #(
    parameter type entry_t = logic
);
    logic push;
    entry_t push_entry;
    logic pop;
    entry_t head_entry;
    logic empty;
    logic full;

    modport ctrl (
        output push,
        output push_entry,
        output pop,
        input head_entry,
        input empty,
        input full
    );

    modport queue (
        input push,
        input push_entry,
        input pop,
        output head_entry,
        output empty,
        output full
    );
endinterface

// ==== mem_pkg.sv ====
package mem_pkg;

    // controller states
    // CLEAR runs the post-reset sweep, IDLE serves the bus,
    // DRAIN empties the write queue ahead of a read,
    // READ issues the RAM read, ACK answers the master
    typedef enum logic [2:0] {
        CLEAR,
        IDLE,
        DRAIN,
        READ,
        ACK
    } ctrl_state_e;

    // word written to every address by the sweep
    localparam wb_pkg::wb_data_t CLEAR_VALUE = '0;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module wb_buffered_ram_tb \
    -f wb_buffered_ram.f \
    -o sim_wb_buffered_ram

./obj_dir/sim_wb_buffered_ram > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== sdp_ram.sv ====
`timescale 1ns/1ps

module sdp_ram #(
    parameter int ADDR_WIDTH = 6
) (
    input logic clk,
    input logic rst,
    ram_port_if.mem ram
);
    import wb_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam int LANE_WIDTH = DATA_WIDTH / SEL_WIDTH;

    // words kept as byte lanes
    logic [SEL_WIDTH-1:0][LANE_WIDTH-1:0] mem [DEPTH];

    // byte-lane write
    always_ff @(posedge clk) begin
        for (int i = 0; i < SEL_WIDTH; i++) begin
            if (ram.wen[i]) begin
                mem[ram.waddr][i] <= ram.wdata[i*LANE_WIDTH +: LANE_WIDTH];
            end
        end
    end

    // registered read, holds its value between reads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram.rdata <= '0;
        end else if (ram.ren) begin
            ram.rdata <= mem[ram.raddr];
        end
    end

endmodule

// ==== sweep_counter.sv ====
`timescale 1ns/1ps

module sweep_counter #(
    parameter int ADDR_WIDTH = 6
) (
    input logic clk,
    input logic rst,
    input logic start,
    output logic [ADDR_WIDTH-1:0] addr,
    output logic done
);

    logic busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else if (start) begin
            addr <= '0;
            busy <= 1'b1;
            done <= 1'b0;
        end else if (busy) begin
            // wraps back to zero after the last word
            addr <= addr + 1'b1;
            if (addr == '1) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// ==== wb_buffered_ram.f ====
wb_pkg.sv
mem_pkg.sv
mem_ifs.sv
sdp_ram.sv
wr_queue.sv
sweep_counter.sv
wb_mem_ctrl.sv
wb_buffered_ram.sv
tb_clk_gen.sv
wb_buffered_ram_sva.sv
wb_buffered_ram_tb.sv

// ==== wb_buffered_ram.sv ====
`timescale 1ns/1ps

module wb_buffered_ram #(
    parameter int ADDR_WIDTH = 6,
    parameter int QUEUE_DEPTH = 4
) (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [ADDR_WIDTH-1:0] adr,
    input wb_pkg::wb_sel_t sel,
    input wb_pkg::wb_data_t dat_w,
    output logic ack,
    output wb_pkg::wb_data_t dat_r,
    output logic init_done
);
    import wb_pkg::*;

    // one posted write
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        wb_data_t data;
        wb_sel_t sel;
    } entry_t;

    logic clr_start;
    logic [ADDR_WIDTH-1:0] clr_addr;
    logic clr_done;

    ram_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) ram_bus ();
    wq_port_if #(.entry_t(entry_t)) wq_bus ();

    wb_mem_ctrl #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) wb_mem_ctrl_i (
        .clk(clk),
        .rst(rst),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .sel(sel),
        .dat_w(dat_w),
        .ack(ack),
        .dat_r(dat_r),
        .init_done(init_done),
        .clr_start(clr_start),
        .clr_addr(clr_addr),
        .clr_done(clr_done),
        .ram(ram_bus),
        .wq(wq_bus)
    );

    sdp_ram #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) sdp_ram_i (
        .clk(clk),
        .rst(rst),
        .ram(ram_bus)
    );

    wr_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .entry_t(entry_t)
    ) wr_queue_i (
        .clk(clk),
        .rst(rst),
        .wq(wq_bus)
    );

    sweep_counter #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) sweep_counter_i (
        .clk(clk),
        .rst(rst),
        .start(clr_start),
        .addr(clr_addr),
        .done(clr_done)
    );

endmodule

// ==== wb_buffered_ram_sva.sv ====
`timescale 1ns/1ps

module wb_buffered_ram_sva (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic init_done
);

    // slave may only answer an active request
    property ack_needs_request;
        @(posedge clk) disable iff (rst)
        ack |-> (cyc && stb);
    endproperty

    // classic cycle, one ack per transfer
    property ack_single_clock;
        @(posedge clk) disable iff (rst)
        ack |=> !ack;
    endproperty

    property no_ack_during_clear;
        @(posedge clk) disable iff (rst)
        !init_done |-> !ack;
    endproperty

    ack_needs_request_a: assert property (ack_needs_request)
        else $error("ack raised without cyc and stb");

    ack_single_clock_a: assert property (ack_single_clock)
        else $error("ack held for more than one clock");

    no_ack_during_clear_a: assert property (no_ack_during_clear)
        else $error("ack raised before init_done");

endmodule

bind wb_buffered_ram wb_buffered_ram_sva wb_buffered_ram_sva_i (
    .clk(clk),
    .rst(rst),
    .cyc(cyc),
    .stb(stb),
    .ack(ack),
    .init_done(init_done)
);

// ==== wb_buffered_ram_tb.sv ====
`timescale 1ns/1ps

module wb_buffered_ram_tb;
    import wb_pkg::*;

    localparam int ADDR_WIDTH = 6;
    localparam int QUEUE_DEPTH = 4;
    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam int ACK_TIMEOUT = 64;
    localparam int INIT_TIMEOUT = 4 * DEPTH;

    logic clk;
    logic rst;
    logic cyc;
    logic stb;
    logic we;
    logic [ADDR_WIDTH-1:0] adr;
    wb_sel_t sel;
    wb_data_t dat_w;
    logic ack;
    wb_data_t dat_r;
    logic init_done;

    int errors;
    logic [31:0] lfsr_state = 32'h96fd;
    // expected memory contents
    wb_data_t model [DEPTH];

    tb_clk_gen #(.PERIOD_NS(4.0)) tb_clk_gen_i (.clk(clk));

    wb_buffered_ram #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) wb_buffered_ram_i (
        .clk(clk),
        .rst(rst),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .sel(sel),
        .dat_w(dat_w),
        .ack(ack),
        .dat_r(dat_r),
        .init_done(init_done)
    );

    // taps x^32 + x^22 + x^2 + x + 1 with one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        logic fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            value = {value[30:0], lfsr_state[31]};
            lfsr_state = {lfsr_state[30:0], fb};
        end
        return value;
    endfunction

    function automatic wb_data_t merge_lanes(wb_data_t old_word, wb_data_t new_word,
                                             wb_sel_t s);
        wb_data_t result;
        result = old_word;
        for (int i = 0; i < SEL_WIDTH; i++) begin
            if (s[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    // ack sampled on falling edges where it has settled
    task automatic wait_ack(output logic seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            if (ack) begin
                seen = 1'b1;
            end else begin
                cycles++;
            end
        end
    endtask

    // starts on a falling edge and returns one clock after ack with the bus still held
    task automatic write_transfer(input logic [ADDR_WIDTH-1:0] a, input wb_data_t d,
                                  input wb_sel_t s);
        logic seen;
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        adr = a;
        sel = s;
        dat_w = d;
        wait_ack(seen);
        assert (seen) else begin
            errors++;
            $display("write to address %h was never acknowledged", a);
        end
        if (seen) begin
            model[a] = merge_lanes(model[a], d, s);
        end
        @(negedge clk);
    endtask

    task automatic read_transfer(input logic [ADDR_WIDTH-1:0] a, output wb_data_t d,
                                 output logic ok);
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b0;
        adr = a;
        wait_ack(ok);
        d = dat_r;
        assert (ok) else begin
            errors++;
            $display("read from address %h was never acknowledged", a);
        end
        @(negedge clk);
    endtask

    task automatic release_bus();
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic wb_write(input logic [ADDR_WIDTH-1:0] a, input wb_data_t d, input wb_sel_t s);
        @(negedge clk);
        write_transfer(a, d, s);
        release_bus();
    endtask

    task automatic wb_read(input logic [ADDR_WIDTH-1:0] a, output wb_data_t d, output logic ok);
        @(negedge clk);
        read_transfer(a, d, ok);
        release_bus();
    endtask

    task automatic compare_word(input logic [ADDR_WIDTH-1:0] a, input wb_data_t got);
        assert (got === model[a]) else begin
            errors++;
            $display("Error: dat_r at address %h expected %h actual %h", a, model[a], got);
        end
    endtask

    task automatic check_read(input logic [ADDR_WIDTH-1:0] a);
        wb_data_t got;
        logic ok;
        wb_read(a, got, ok);
        if (ok) begin
            compare_word(a, got);
        end
    endtask

    task automatic clear_sweep_reads();
        int cycles;
        cycles = 0;
        while (!init_done && cycles < INIT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (init_done) else begin
            errors++;
            $display("init_done did not rise after the clear sweep");
        end
        for (int i = 0; i < DEPTH; i++) begin
            check_read(ADDR_WIDTH'(i));
        end
    endtask

    task automatic full_word_writes();
        for (int i = 0; i < 8; i++) begin
            wb_write(ADDR_WIDTH'(i), random_bits(32), 4'hf);
        end
        for (int i = 0; i < 8; i++) begin
            check_read(ADDR_WIDTH'(i));
        end
    endtask

    task automatic partial_lane_writes();
        logic [ADDR_WIDTH-1:0] a;
        for (int i = 0; i < 8; i++) begin
            a = ADDR_WIDTH'(i);
            wb_write(a, random_bits(32), 4'(random_bits(4)));
            check_read(a);
        end
    endtask

    // writes follow each other with no idle clock so the queue fills
    task automatic queue_back_pressure();
        @(negedge clk);
        for (int i = 0; i < 3 * QUEUE_DEPTH; i++) begin
            write_transfer(ADDR_WIDTH'(16 + i), random_bits(32), 4'(random_bits(4)));
        end
        release_bus();
        for (int i = 0; i < 3 * QUEUE_DEPTH; i++) begin
            check_read(ADDR_WIDTH'(16 + i));
        end
    endtask

    // newest write must win over the RAM copy
    task automatic read_after_write();
        logic [ADDR_WIDTH-1:0] a;
        wb_data_t got;
        logic ok;
        a = ADDR_WIDTH'(40);
        @(negedge clk);
        write_transfer(a, random_bits(32), 4'hf);
        write_transfer(a, random_bits(32), 4'b0101);
        write_transfer(a, random_bits(32), 4'b1000);
        read_transfer(a, got, ok);
        if (ok) begin
            compare_word(a, got);
        end
        write_transfer(a, random_bits(32), 4'hf);
        read_transfer(a, got, ok);
        if (ok) begin
            compare_word(a, got);
        end
        release_bus();
    endtask

    task automatic random_traffic();
        logic is_write;
        logic [ADDR_WIDTH-1:0] a;
        for (int i = 0; i < 200; i++) begin
            is_write = random_bits(1) != 0;
            a = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
            if (is_write) begin
                wb_write(a, random_bits(32), 4'(random_bits(4)));
            end else begin
                check_read(a);
            end
        end
    endtask

    initial begin
        #100_000;
        $display("simulation time limit reached");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        sel = '0;
        dat_w = '0;
        errors = 0;
        for (int i = 0; i < DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        clear_sweep_reads();
        full_word_writes();
        partial_lane_writes();
        queue_back_pressure();
        read_after_write();
        random_traffic();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== wb_mem_ctrl.sv ====
`timescale 1ns/1ps

module wb_mem_ctrl #(
    parameter int ADDR_WIDTH = 6
) (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [ADDR_WIDTH-1:0] adr,
    input wb_pkg::wb_sel_t sel,
    input wb_pkg::wb_data_t dat_w,
    output logic ack,
    output wb_pkg::wb_data_t dat_r,
    output logic init_done,
    output logic clr_start,
    input logic [ADDR_WIDTH-1:0] clr_addr,
    input logic clr_done,
    ram_port_if.ctrl ram,
    wq_port_if.ctrl wq
);
    import wb_pkg::*;
    import mem_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic rd_req;
    logic wr_req;
    logic sweep_wr;

    assign rd_req = cyc & stb & ~we;
    assign wr_req = cyc & stb & we;

    // counter is busy from the clock after clr_start until done
    assign sweep_wr = (state == CLEAR) & ~clr_start & ~clr_done;

    assign ack = (state == ACK);
    assign dat_r = ram.rdata;
    assign init_done = (state != CLEAR);

    // writes are posted and acked once queued
    assign wq.push = (state == IDLE) & wr_req & ~wq.full;

    always_comb begin
        wq.push_entry.addr = adr;
        wq.push_entry.data = dat_w;
        wq.push_entry.sel = sel;
    end

    // retire queued writes in DRAIN and in IDLE unless a write is being queued
    assign wq.pop = ~wq.empty & ((state == DRAIN) | ((state == IDLE) & ~wq.push));

    always_comb begin
        if (state == CLEAR) begin
            ram.wen = sweep_wr ? {SEL_WIDTH{1'b1}} : '0;
            ram.waddr = clr_addr;
            ram.wdata = CLEAR_VALUE;
        end else begin
            ram.wen = wq.pop ? wq.head_entry.sel : '0;
            ram.waddr = wq.head_entry.addr;
            ram.wdata = wq.head_entry.data;
        end
    end

    // read port only after the queue is empty
    assign ram.ren = (state == READ);
    assign ram.raddr = adr;

    always_comb begin
        state_next = state;
        case (state)
            CLEAR: begin
                if (clr_done) begin
                    state_next = IDLE;
                end
            end
            IDLE: begin
                if (wr_req && !wq.full) begin
                    state_next = ACK;
                end else if (rd_req) begin
                    // this cycle pops one entry already
                    state_next = wq.empty ? READ : DRAIN;
                end
            end
            DRAIN: begin
                if (wq.empty) begin
                    state_next = READ;
                end
            end
            READ: begin
                state_next = ACK;
            end
            ACK: begin
                // master drops stb or starts its next transfer
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= CLEAR;
        end else begin
            state <= state_next;
        end
    end

    // one-clock start pulse right after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clr_start <= 1'b1;
        end else begin
            clr_start <= 1'b0;
        end
    end

endmodule

// ==== wb_pkg.sv ====
package wb_pkg;

    // bus word, also the RAM word
    localparam int DATA_WIDTH = 32;

    // one select bit per byte lane
    localparam int SEL_WIDTH = DATA_WIDTH / 8;

    typedef logic [DATA_WIDTH-1:0] wb_data_t;
    typedef logic [SEL_WIDTH-1:0] wb_sel_t;

endpackage

// ==== wr_queue.sv ====
`timescale 1ns/1ps

module wr_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter type entry_t = logic
) (
    input logic clk,
    input logic rst,
    wq_port_if.queue wq
);

    localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

    entry_t slots [QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0] head;
    logic [PTR_WIDTH-1:0] tail;
    // one bit wider than the pointers to tell full from empty
    logic [PTR_WIDTH:0] count;

    assign wq.head_entry = slots[head];
    assign wq.empty = (count == '0);
    assign wq.full = (count == (PTR_WIDTH + 1)'(QUEUE_DEPTH));

    always_ff @(posedge clk) begin
        if (wq.push) begin
            slots[tail] <= wq.push_entry;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (wq.push) begin
                tail <= tail + 1'b1;
            end
            if (wq.pop) begin
                head <= head + 1'b1;
            end
        end
    end

    // push and pop together leave the count alone
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wq.push, wq.pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule
